// File: pkt_comm.f
+incdir+verilog
verilog/pkt_format_pkg.sv
verilog/pkt_ctrl_pkg.sv
verilog/axis_byte_fifo.sv
verilog/inpkt_header.sv
verilog/ack_builder.sv
verilog/word_serializer.sv
verilog/status_ctrl.sv
verilog/pkt_comm_top.sv
tests/tb_pkt_comm.sv

// File: tests/pkt_comm_tests.dat
// Records, hex: 01 n bytes = packet, 02 = clear_error pulse, 03 w0 w1 w2 = reply,
// 04 status err = status check, 05 = drain replies, 06 v = idle level,
// 07 r = m_axis_tready rate in 16, 00 = end
07 08
// One good packet of each type 1 to 4
01 0a 02 01 03 00 34 12 aa 55 01 d8      03 0003 1234 0100
01 09 02 02 02 00 ef be ff ff 53         03 0002 beef 01fe
01 0b 02 03 04 00 07 00 01 02 03 04 06   03 0004 0007 000a
01 08 02 04 01 00 c3 a5 80 e1            03 0001 a5c3 0080
06 00 05 06 01 04 00 00
// Bad version, type, length 1025 and checksum, each cleared and followed by a good packet
01 08 03 01 01 00 01 00 11 12   04 08 01 02 04 00 00
01 08 02 01 01 00 40 00 5a 18   03 0001 0040 005a 05
01 08 02 07 01 00 02 00 11 12   04 04 01 02 04 00 00
01 08 02 01 01 00 41 00 5a 19   03 0001 0041 005a 05
01 08 02 01 01 04 03 00 11 12   04 02 01 02 04 00 00
01 08 02 01 01 00 42 00 5a 1a   03 0001 0042 005a 05
01 08 02 01 01 00 09 00 33 ff   04 01 01 02 04 00 00
01 08 02 01 01 00 43 00 5a 1b   03 0001 0043 005a 05
// Reset packet with payload, no reply, the next sum starts from zero
01 09 02 05 02 00 99 00 10 20 ac   04 00 00 05
01 09 02 02 02 00 50 00 01 01 52   03 0002 0050 0002 05
// Burst of short packets against a slow output
07 01
01 08 02 01 01 00 10 00 20 32   03 0001 0010 0020
01 08 02 01 01 00 11 00 21 32   03 0001 0011 0021
01 08 02 01 01 00 12 00 22 32   03 0001 0012 0022
01 08 02 01 01 00 13 00 23 32   03 0001 0013 0023
01 08 02 01 01 00 14 00 24 32   03 0001 0014 0024
01 08 02 01 01 00 15 00 25 32   03 0001 0015 0025
01 08 02 01 01 00 16 00 26 32   03 0001 0016 0026
01 08 02 01 01 00 17 00 27 32   03 0001 0017 0027
01 08 02 01 01 00 18 00 28 32   03 0001 0018 0028
01 08 02 01 01 00 19 00 29 32   03 0001 0019 0029
01 08 02 01 01 00 1a 00 2a 32   03 0001 001a 002a
01 08 02 01 01 00 1b 00 2b 32   03 0001 001b 002b
01 08 02 01 01 00 1c 00 2c 32   03 0001 001c 002c
01 08 02 01 01 00 1d 00 2d 32   03 0001 001d 002d
01 08 02 01 01 00 1e 00 2e 32   03 0001 001e 002e
01 08 02 01 01 00 1f 00 2f 32   03 0001 001f 002f
05 07 10 06 01
00

// File: tests/tb_pkt_comm.sv
// ======================================================================
// Testbench for the packet front end
// Replays packets and control events from a vector file, checks replies
// ======================================================================
`timescale 1ns/1ps

module tb_pkt_comm;

  localparam int VEC_WORDS = 1024;

  logic       CLK;
  logic       RSTN;
  logic [7:0] s_axis_tdata;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  logic [7:0] m_axis_tdata;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  logic       m_axis_tlast;
  logic       clear_error;
  logic [3:0] pkt_comm_status;
  logic       error_o;
  logic       idle;

  logic [15:0] vec [VEC_WORDS];
  logic [15:0] exp_q [$];
  logic [7:0]  rx_bytes [6];
  logic [31:0] gap_state;
  logic [31:0] rdy_state;
  logic [4:0]  rdy_rate;
  int          byte_idx = 0;
  int          rx_count = 0;
  int          exp_listed = 0;
  int          exp_total = 0;
  int          stall_cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          wd_cycles = 0;

  pkt_comm_top UUT (
    .CLK             (CLK),
    .RSTN            (RSTN),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .m_axis_tdata    (m_axis_tdata),
    .m_axis_tvalid   (m_axis_tvalid),
    .m_axis_tready   (m_axis_tready),
    .m_axis_tlast    (m_axis_tlast),
    .clear_error     (clear_error),
    .pkt_comm_status (pkt_comm_status),
    .error_o         (error_o),
    .idle            (idle)
  );

  always #4 CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic expect_value(input string name, input logic [7:0] want,
                              input logic [7:0] got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error %s: expected %h, got %h", name, want, got);
    end
  endtask

  // Six bytes make count, id and sum, low byte first
  task automatic compare_reply();
    logic [15:0] got;
    logic [15:0] want;
    int          k;
    if (exp_q.size() < 3) begin
      errors++;
      $display("Reply %0d arrived although no reply was expected", rx_count);
    end else begin
      for (k = 0; k < 3; k++) begin
        got  = {rx_bytes[2*k+1], rx_bytes[2*k]};
        want = exp_q.pop_front();
        checks++;
        if (got !== want) begin
          errors++;
          $display("** Error m_axis_tdata reply %0d word %0d: expected %h, got %h",
                   rx_count, k, want, got);
        end
      end
    end
    rx_count++;
  endtask

  // Output ready high rdy_rate times in 16
  // Valid and ready both hold until the next rising edge, which takes the beat
  always @(negedge CLK) begin
    rdy_state     = lcg_next(rdy_state);
    m_axis_tready = (rdy_state[19:16] < rdy_rate);
    if (RSTN && m_axis_tvalid && m_axis_tready) begin
      rx_bytes[byte_idx] = m_axis_tdata;
      checks++;
      if (m_axis_tlast !== (byte_idx == 5)) begin
        errors++;
        if (byte_idx == 5) begin
          $display("Missing tlast at the end of reply %0d", rx_count);
        end else begin
          $display("Stray tlast on byte %0d of reply %0d", byte_idx, rx_count);
        end
      end
      if (byte_idx == 5) begin
        compare_reply();
        byte_idx = 0;
      end else begin
        byte_idx++;
      end
    end
  end

  // Random gaps before a byte, then hold until accepted
  task automatic drive_byte(input logic [7:0] b);
    @(negedge CLK);
    gap_state = lcg_next(gap_state);
    while (gap_state[18:16] == 3'd0) begin
      s_axis_tvalid = 1'b0;
      @(negedge CLK);
      gap_state = lcg_next(gap_state);
    end
    s_axis_tdata  = b;
    s_axis_tvalid = 1'b1;
    // Ready only moves on a rising edge and is settled here
    while (!s_axis_tready) begin
      stall_cycles++;
      @(negedge CLK);
    end
    @(posedge CLK);
  endtask

  task automatic send_packet(input int at);
    int n;
    int k;
    n = vec[at+1];
    for (k = 0; k < n; k++) begin
      drive_byte(vec[at+2+k][7:0]);
    end
    @(negedge CLK);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic pulse_clear();
    @(negedge CLK);
    clear_error = 1'b1;
    @(negedge CLK);
    clear_error = 1'b0;
  endtask

  task automatic verify_status(input logic [3:0] want_status, input logic want_err);
    int t;
    t = 0;
    @(negedge CLK);
    while (pkt_comm_status !== want_status && t < 100) begin
      @(negedge CLK);
      t++;
    end
    expect_value("pkt_comm_status", {4'd0, want_status}, {4'd0, pkt_comm_status});
    // error_o trails the status bits by a cycle
    repeat (2) @(negedge CLK);
    expect_value("error_o", {7'd0, want_err}, {7'd0, error_o});
  endtask

  task automatic drain_replies();
    int t;
    t = 0;
    while (rx_count < exp_listed && t < 4000) begin
      @(negedge CLK);
      t++;
    end
    checks++;
    if (rx_count < exp_listed) begin
      errors++;
      $display("Only %0d of %0d replies arrived", rx_count, exp_listed);
    end
  endtask

  task automatic await_idle(input logic want);
    int t;
    t = 0;
    @(negedge CLK);
    while (idle !== want && t < 200) begin
      @(negedge CLK);
      t++;
    end
    expect_value("idle", {7'd0, want}, {7'd0, idle});
  endtask

  initial begin
    int p;
    CLK           = 1'b0;
    RSTN          = 1'b0;
    s_axis_tdata  = 8'h00;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    clear_error   = 1'b0;
    rdy_rate      = 5'd8;
    gap_state     = 32'hc26d;
    rdy_state     = ~32'hc26d;
    for (p = 0; p < VEC_WORDS; p++) begin
      vec[p] = 16'h0000;
    end
    $readmemh("tests/pkt_comm_tests.dat", vec);

    // Collect every expected reply and size the watchdog
    p = 0;
    while (p < VEC_WORDS && vec[p] != 16'h0000) begin
      case (vec[p])
        16'h01: p = p + 2 + vec[p+1];
        16'h03: begin
          exp_q.push_back(vec[p+1]);
          exp_q.push_back(vec[p+2]);
          exp_q.push_back(vec[p+3]);
          p = p + 4;
        end
        16'h04: p = p + 3;
        16'h06, 16'h07: p = p + 2;
        default: p = p + 1;
      endcase
    end
    exp_total = exp_q.size() / 3;
    wd_cycles = (p + 1 + 6 * exp_total) * 40;

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RSTN = 1'b1;
    @(negedge CLK);
    expect_value("idle", 8'h01, {7'd0, idle});
    expect_value("m_axis_tvalid", 8'h00, {7'd0, m_axis_tvalid});
    expect_value("error_o", 8'h00, {7'd0, error_o});
    expect_value("pkt_comm_status", 8'h00, {4'd0, pkt_comm_status});

    p = 0;
    while (p < VEC_WORDS && vec[p] != 16'h0000) begin
      case (vec[p])
        16'h01: begin
          send_packet(p);
          p = p + 2 + vec[p+1];
        end
        16'h02: begin
          pulse_clear();
          p = p + 1;
        end
        16'h03: begin
          exp_listed++;
          p = p + 4;
        end
        16'h04: begin
          verify_status(vec[p+1][3:0], vec[p+2][0]);
          p = p + 3;
        end
        16'h05: begin
          drain_replies();
          p = p + 1;
        end
        16'h06: begin
          await_idle(vec[p+1][0]);
          p = p + 2;
        end
        16'h07: begin
          @(posedge CLK);
          rdy_rate = vec[p+1][4:0];
          p = p + 2;
        end
        default: begin
          errors++;
          $display("Unknown record %h at word %0d of the vector file", vec[p], p);
          p = p + 1;
        end
      endcase
    end

    drain_replies();
    repeat (20) @(negedge CLK);
    checks++;
    if (rx_count != exp_total || byte_idx != 0) begin
      errors++;
      $display("Expected %0d replies but received %0d and %0d loose bytes",
               exp_total, rx_count, byte_idx);
    end
    // The burst must have pushed back on the input
    checks++;
    if (stall_cycles == 0) begin
      errors++;
      $display("s_axis_tready never dropped while input was waiting");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the vector file
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge CLK);
    $display("Timeout after %0d cycles, the run did not complete", wd_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog/ack_builder.sv
// ======================================================================
// Acknowledgement builder
// Counts and sums payload, queues count, id and sum per good packet
// ======================================================================
`timescale 1ns/1ps
`include "pkt_comm_macros.svh"

module ack_builder (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  logic                    soft_rst,
  input  logic                    data_strobe,
  input  logic [7:0]              byte_in,
  input  logic                    pkt_good,
  input  pkt_format_pkg::pkt_id_t pkt_id,
  output logic                    room,
  output logic [15:0]             word,
  output logic                    word_valid,
  output logic                    word_last,
  input  logic                    word_take,
  output logic                    busy
);

  import pkt_format_pkg::*;

  localparam int PW = $clog2(`REPLY_DEPTH);
  localparam int LW = $clog2(`REPLY_DEPTH + 1);
  localparam logic [LW-1:0] ROOM_MAX = LW'(`REPLY_DEPTH - 3);
  localparam logic [PW-1:0] LAST_IDX = PW'(`REPLY_DEPTH - 1);
  localparam logic [PW-1:0] LAST_SLOT = PW'(`REPLY_DEPTH - 3);

  // Bit 16 tags the final word of a reply
  logic [16:0]   mem [`REPLY_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [LW-1:0] level;
  pkt_len_t      count;
  pkt_sum_t      sum;

  assign room       = (level <= ROOM_MAX);
  assign word_valid = (level != '0);
  assign word       = mem[rd_ptr][15:0];
  assign word_last  = mem[rd_ptr][16];
  assign busy       = word_valid;

  // Writes land on slot multiples of three, so a reply never wraps
  always_ff @(posedge CLK) begin
    if (pkt_good) begin
      mem[wr_ptr]        <= {1'b0, count};
      mem[wr_ptr + 1'b1] <= {1'b0, pkt_id};
      mem[wr_ptr + 2'd2] <= {1'b1, sum};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
      count  <= '0;
      sum    <= '0;
    end else if (soft_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
      count  <= '0;
      sum    <= '0;
    end else begin
      if (pkt_good) begin
        count  <= '0;
        sum    <= '0;
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 2'd3;
      end else if (data_strobe) begin
        count <= count + 1'b1;
        sum   <= sum + {8'd0, byte_in};
      end
      if (word_take) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      level <= level + (pkt_good ? LW'(3) : LW'(0)) - (word_take ? LW'(1) : LW'(0));
    end
  end

  // Parser only releases a reply after seeing room
  a_write_has_room: assert property (@(posedge CLK) disable iff (!RSTN)
    pkt_good |-> (level <= ROOM_MAX));

endmodule

// File: verilog/axis_byte_fifo.sv
// ======================================================================
// Input byte FIFO
// Accepts AXI-Stream bytes, flushable, read by the parser
// ======================================================================
`timescale 1ns/1ps
`include "pkt_comm_macros.svh"

module axis_byte_fifo (
  input  logic       CLK,
  input  logic       RSTN,
  input  logic       flush,
  input  logic [7:0] s_axis_tdata,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready,
  input  logic       rd_en,
  output logic [7:0] byte_out,
  output logic       empty
);

  localparam int AW = $clog2(`IN_FIFO_DEPTH);

  logic [7:0]  mem [`IN_FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        push;

  // Same index with differing wrap bits means full
  assign full          = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty         = (wr_ptr == rd_ptr);
  assign s_axis_tready = ~full;
  assign push          = s_axis_tvalid & ~full & ~flush;
  assign byte_out      = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= s_axis_tdata;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Parser must only pop what is there
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (!RSTN) rd_en |-> !empty);

endmodule

// File: verilog/inpkt_header.sv
// ======================================================================
// Input packet parser
// Checks version, type, length and checksum, steers payload bytes
// ======================================================================
`timescale 1ns/1ps
`include "pkt_comm_macros.svh"

module inpkt_header (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  logic                    soft_rst,
  input  logic [7:0]              byte_in,
  input  logic                    empty,
  input  logic                    room,
  output logic                    rd_en,
  output logic                    data_strobe,
  output logic                    pkt_good,
  output pkt_format_pkg::pkt_id_t pkt_id,
  output logic                    busy,
  output logic [3:0]              err_bits,
  output logic                    reset_done
);

  import pkt_format_pkg::*;
  import pkt_ctrl_pkg::*;

  parse_state_e state;
  pkt_type_e    type_r;
  logic [7:0]   len_lo;
  pkt_id_t      id_r;
  pkt_len_t     cnt;
  logic [7:0]   csum;
  pkt_len_t     hdr_len;

  assign hdr_len = {byte_in, len_lo};

  // Checksum byte waits for a full reply slot; ERROR stops reading
  always_comb begin
    case (state)
      ST_ERROR: rd_en = 1'b0;
      ST_CSUM:  rd_en = ~empty & room & ~soft_rst;
      default:  rd_en = ~empty & ~soft_rst;
    endcase
  end

  assign data_strobe = rd_en && (state == ST_DATA);
  assign busy        = (state != ST_VERSION);
  assign pkt_id      = id_r;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state      <= ST_VERSION;
      err_bits   <= '0;
      pkt_good   <= 1'b0;
      reset_done <= 1'b0;
    end else if (soft_rst) begin
      state      <= ST_VERSION;
      err_bits   <= '0;
      pkt_good   <= 1'b0;
      reset_done <= 1'b0;
    end else begin
      pkt_good   <= 1'b0;
      reset_done <= 1'b0;
      if (rd_en) begin
        case (state)
          ST_VERSION: begin
            if (byte_in != `PKT_COMM_VERSION) begin
              err_bits[ERR_VERSION] <= 1'b1;
              state                 <= ST_ERROR;
            end else begin
              state <= ST_TYPE;
            end
          end
          ST_TYPE: begin
            if (!type_legal(byte_in)) begin
              err_bits[ERR_TYPE] <= 1'b1;
              state              <= ST_ERROR;
            end else begin
              state <= ST_LEN_LO;
            end
          end
          ST_LEN_LO: state <= ST_LEN_HI;
          ST_LEN_HI: begin
            if (hdr_len == '0 || hdr_len > `PKT_MAX_LEN) begin
              err_bits[ERR_LEN] <= 1'b1;
              state             <= ST_ERROR;
            end else begin
              state <= ST_ID_LO;
            end
          end
          ST_ID_LO: state <= ST_ID_HI;
          ST_ID_HI: state <= ST_DATA;
          ST_DATA: begin
            if (cnt == 16'd1) begin
              state <= ST_CSUM;
            end
          end
          ST_CSUM: begin
            if (byte_in != csum) begin
              err_bits[ERR_CHECKSUM] <= 1'b1;
              state                  <= ST_ERROR;
            end else begin
              // Reset packets are swallowed here, no reply
              pkt_good   <= (type_r != RESET);
              reset_done <= (type_r == RESET);
              state      <= ST_VERSION;
            end
          end
          default: state <= ST_ERROR;
        endcase
      end
    end
  end

  // Header fields, running XOR and payload down-counter
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      csum <= (state == ST_VERSION) ? byte_in : (csum ^ byte_in);
      case (state)
        ST_TYPE:   type_r     <= pkt_type_e'(byte_in);
        ST_LEN_LO: len_lo     <= byte_in;
        ST_LEN_HI: cnt        <= hdr_len;
        ST_ID_LO:  id_r[7:0]  <= byte_in;
        ST_ID_HI:  id_r[15:8] <= byte_in;
        ST_DATA:   cnt        <= cnt - 1'b1;
        default:   ;
      endcase
    end
  end

  // Payload strobes never outrun the announced length
  a_strobe_in_data: assert property (@(posedge CLK) disable iff (!RSTN)
    data_strobe |-> (state == ST_DATA) && (cnt != '0));

  // A reset packet must never produce a reply
  a_no_reset_reply: assert property (@(posedge CLK) disable iff (!RSTN)
    pkt_good |-> (type_r != RESET));

endmodule

// File: verilog/pkt_comm_macros.svh
// ======================================================================
// Packet front end constants
// Protocol version, length limit, buffer depths and idle delay
// ======================================================================
`ifndef PKT_COMM_MACROS_SVH
`define PKT_COMM_MACROS_SVH

// Accepted version byte at offset 0
`define PKT_COMM_VERSION 8'd2

// Largest legal payload, bytes
`define PKT_MAX_LEN 16'd1024

// Input byte FIFO entries, power of two
`define IN_FIFO_DEPTH 64

// Reply FIFO words, room for four replies of three words
`define REPLY_DEPTH 12

// Stages in the idle delay line
`define IDLE_DELAY 6

`endif

// File: verilog/pkt_comm_top.sv
// ======================================================================
// Packet front end top level
// Input FIFO, parser, reply builder, serializer and status control
// ======================================================================
`timescale 1ns/1ps

module pkt_comm_top (
  input  logic       CLK,
  input  logic       RSTN,
  input  logic [7:0] s_axis_tdata,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready,
  output logic [7:0] m_axis_tdata,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output logic       m_axis_tlast,
  input  logic       clear_error,
  output logic [3:0] pkt_comm_status,
  output logic       error_o,
  output logic       idle
);

  import pkt_format_pkg::*;

  logic        soft_rst;
  logic        flush;
  logic [7:0]  in_byte;
  logic        in_empty;
  logic        rd_en;
  logic        data_strobe;
  logic        pkt_good;
  pkt_id_t     pkt_id;
  logic        room;
  logic        parser_busy;
  logic        reset_done;
  logic [15:0] word;
  logic        word_valid;
  logic        word_last;
  logic        word_take;
  logic        ack_busy;
  logic        ser_busy;

  axis_byte_fifo u_in_fifo (
    .CLK           (CLK),
    .RSTN          (RSTN),
    .flush         (flush),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .rd_en         (rd_en),
    .byte_out      (in_byte),
    .empty         (in_empty)
  );

  inpkt_header u_parser (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .soft_rst    (soft_rst),
    .byte_in     (in_byte),
    .empty       (in_empty),
    .room        (room),
    .rd_en       (rd_en),
    .data_strobe (data_strobe),
    .pkt_good    (pkt_good),
    .pkt_id      (pkt_id),
    .busy        (parser_busy),
    .err_bits    (pkt_comm_status),
    .reset_done  (reset_done)
  );

  ack_builder u_ack (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .soft_rst    (soft_rst),
    .data_strobe (data_strobe),
    .byte_in     (in_byte),
    .pkt_good    (pkt_good),
    .pkt_id      (pkt_id),
    .room        (room),
    .word        (word),
    .word_valid  (word_valid),
    .word_last   (word_last),
    .word_take   (word_take),
    .busy        (ack_busy)
  );

  word_serializer u_ser (
    .CLK           (CLK),
    .RSTN          (RSTN),
    .soft_rst      (soft_rst),
    .word          (word),
    .word_valid    (word_valid),
    .word_last     (word_last),
    .word_take     (word_take),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .busy          (ser_busy)
  );

  status_ctrl u_status (
    .CLK           (CLK),
    .RSTN          (RSTN),
    .clear_error   (clear_error),
    .reset_done    (reset_done),
    .err_bits      (pkt_comm_status),
    .s_axis_tvalid (s_axis_tvalid),
    .parser_busy   (parser_busy),
    .ack_busy      (ack_busy),
    .ser_busy      (ser_busy),
    .soft_rst      (soft_rst),
    .flush         (flush),
    .error_o       (error_o),
    .idle          (idle)
  );

endmodule

// File: verilog/pkt_ctrl_pkg.sv
// ======================================================================
// Control types for the packet front end
// Parser and serializer states, status bit positions
// ======================================================================
package pkt_ctrl_pkg;

  // Parser walks the header one byte per state
  typedef enum logic [3:0] {
    ST_VERSION, ST_TYPE, ST_LEN_LO, ST_LEN_HI, ST_ID_LO, ST_ID_HI,
    ST_DATA, ST_CSUM, ST_ERROR
  } parse_state_e;

  // Which half of the held word goes out next
  typedef enum logic {
    SER_LOW,
    SER_HIGH
  } ser_state_e;

  // Bit positions in pkt_comm_status
  typedef enum logic [1:0] {
    ERR_CHECKSUM = 2'd0,
    ERR_LEN      = 2'd1,
    ERR_TYPE     = 2'd2,
    ERR_VERSION  = 2'd3
  } err_bit_e;

endpackage

// File: verilog/pkt_format_pkg.sv
// ======================================================================
// Packet format types
// Packet type codes and the header field types
// ======================================================================
package pkt_format_pkg;

  // Packet type byte; anything outside 1..5 is rejected
  typedef enum logic [7:0] {
    WORD_LIST     = 8'd1,
    WORD_GEN      = 8'd2,
    CMP_CONFIG    = 8'd3,
    TEMPLATE_LIST = 8'd4,
    RESET         = 8'd5
  } pkt_type_e;

  // Payload length, sent low byte first
  typedef logic [15:0] pkt_len_t;

  // Packet id, echoed in the reply
  typedef logic [15:0] pkt_id_t;

  // Payload byte sum, modulo 2^16
  typedef logic [15:0] pkt_sum_t;

  // True for the defined type codes
  function automatic logic type_legal(logic [7:0] t);
    return (t >= WORD_LIST) && (t <= RESET);
  endfunction

endpackage

// File: verilog/status_ctrl.sv
// ======================================================================
// Status and soft reset control
// Soft reset and flush, sticky error flag, delayed idle level
// ======================================================================
`timescale 1ns/1ps
`include "pkt_comm_macros.svh"

module status_ctrl (
  input  logic       CLK,
  input  logic       RSTN,
  input  logic       clear_error,
  input  logic       reset_done,
  input  logic [3:0] err_bits,
  input  logic       s_axis_tvalid,
  input  logic       parser_busy,
  input  logic       ack_busy,
  input  logic       ser_busy,
  output logic       soft_rst,
  output logic       flush,
  output logic       error_o,
  output logic       idle
);

  logic [`IDLE_DELAY-1:0] idle_line;
  logic                   idle_now;

  // clear_error doubles as force reset out of a stuck ERROR state
  assign soft_rst = clear_error | reset_done;
  assign flush    = clear_error;

  assign idle_now = ~s_axis_tvalid & ~parser_busy & ~ack_busy & ~ser_busy;
  assign idle     = idle_line[`IDLE_DELAY-1];

  // Reset packets clear the parser bits but not this flag
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      error_o <= 1'b0;
    end else if (clear_error) begin
      error_o <= 1'b0;
    end else if (|err_bits) begin
      error_o <= 1'b1;
    end
  end

  // Line starts all ones so idle reads high straight out of reset
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      idle_line <= '1;
    end else begin
      idle_line <= {idle_line[`IDLE_DELAY-2:0], idle_now};
    end
  end

endmodule

// File: verilog/word_serializer.sv
// ======================================================================
// Word to byte serializer
// 16-bit reply words out on 8-bit AXI-Stream, low byte first
// ======================================================================
`timescale 1ns/1ps

module word_serializer (
  input  logic        CLK,
  input  logic        RSTN,
  input  logic        soft_rst,
  input  logic [15:0] word,
  input  logic        word_valid,
  input  logic        word_last,
  output logic        word_take,
  output logic [7:0]  m_axis_tdata,
  output logic        m_axis_tvalid,
  input  logic        m_axis_tready,
  output logic        m_axis_tlast,
  output logic        busy
);

  import pkt_ctrl_pkg::*;

  ser_state_e  state;
  logic [15:0] hold;
  logic        hold_last;
  logic        full;

  // Next word only once both bytes of the held one are gone
  assign word_take     = word_valid & ~full;
  assign m_axis_tvalid = full;
  assign m_axis_tdata  = (state == SER_HIGH) ? hold[15:8] : hold[7:0];
  assign m_axis_tlast  = full && (state == SER_HIGH) && hold_last;
  assign busy          = full;

  always_ff @(posedge CLK) begin
    if (word_take) begin
      hold      <= word;
      hold_last <= word_last;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state <= SER_LOW;
      full  <= 1'b0;
    end else if (soft_rst) begin
      state <= SER_LOW;
      full  <= 1'b0;
    end else if (word_take) begin
      state <= SER_LOW;
      full  <= 1'b1;
    end else if (full && m_axis_tready) begin
      if (state == SER_LOW) begin
        state <= SER_HIGH;
      end else begin
        state <= SER_LOW;
        full  <= 1'b0;
      end
    end
  end

  // Stalled beat holds its data
  a_stable_stall: assert property (@(posedge CLK) disable iff (!RSTN || soft_rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata));

endmodule
